// ==== pcx_arb.sv ====
// PCX arbiter
// Picks one requesting core per L2 bank each cycle in round-robin order,
// pulses that core's grant and registers the packet onto the bank link
// in inverted form together with a one-cycle ready strobe

`timescale 1ns/1ps
`default_nettype none

`include "pcx_consts.svh"

module pcx_arb (
   input  logic                        rclk,
   input  logic                        rst_n,
   input  pcx_link_pkg::pcx_core_vec_t core_req,
   input  pcx_pkt_pkg::pcx_pkt_t       core_pkt     [`PCX_N_CORES],
   input  pcx_link_pkg::pcx_bank_vec_t stall_pq_buf,
   output pcx_link_pkg::pcx_core_vec_t core_gnt,
   output pcx_link_pkg::pcx_link_t     px_link      [`PCX_N_BANKS]
);

   import pcx_pkt_pkg::*;
   import pcx_link_pkg::*;

   ////////////////////////////////////////
   // Declarations
   ////////////////////////////////////////

   // Requesting cores per bank, already masked by stall
   pcx_core_vec_t          cand    [`PCX_N_BANKS];
   // Round-robin pointer per bank
   logic [`PCX_CORE_W-1:0] rr_ptr  [`PCX_N_BANKS];
   // Winner per bank
   pcx_bank_vec_t          win_vld;
   logic [`PCX_CORE_W-1:0] win_id  [`PCX_N_BANKS];
   pcx_pkt_t               sel_pkt [`PCX_N_BANKS];

   ////////////////////////////////////////
   // Candidate selection
   ////////////////////////////////////////

   // A core competes only for the bank named in its packet
   always_comb begin
      for (int b = 0; b < `PCX_N_BANKS; b++) begin
         for (int c = 0; c < `PCX_N_CORES; c++) begin
            cand[b][c] = core_req[c] &&
                         (int'(core_pkt[c].bank) == b) &&
                         !stall_pq_buf[b];
         end
      end
   end

   ////////////////////////////////////////
   // Round-robin pick
   ////////////////////////////////////////

   // Scan from the far end down to the pointer
   // so the candidate nearest the pointer is the last one written
   always_comb begin
      int idx;
      for (int b = 0; b < `PCX_N_BANKS; b++) begin
         win_vld[b] = 1'b0;
         win_id[b]  = '0;
         for (int k = `PCX_N_CORES - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr[b]) + k) % `PCX_N_CORES;
            if (cand[b][idx]) begin
               win_vld[b] = 1'b1;
               win_id[b]  = idx[`PCX_CORE_W-1:0];
            end
         end
      end
   end

   // Packet mux per bank
   always_comb begin
      for (int b = 0; b < `PCX_N_BANKS; b++) begin
         sel_pkt[b] = core_pkt[win_id[b]];
      end
   end

   ////////////////////////////////////////
   // Grants
   ////////////////////////////////////////

   // Combinational in the winning cycle
   // A core targets one bank, so at most one bank sets its bit
   always_comb begin
      core_gnt = '0;
      for (int b = 0; b < `PCX_N_BANKS; b++) begin
         if (win_vld[b]) begin
            core_gnt[win_id[b]] = 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Pointers and link registers
   ////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         for (int b = 0; b < `PCX_N_BANKS; b++) begin
            rr_ptr[b]        <= '0;
            px_link[b].rdy   <= 1'b0;
            // Inverted idle zero
            px_link[b].pkt_l <= '1;
         end
      end else begin
         for (int b = 0; b < `PCX_N_BANKS; b++) begin
            px_link[b].rdy <= win_vld[b];
            // Link goes back to idle when no grant
            if (win_vld[b]) begin
               px_link[b].pkt_l <= pcx_pkt_t'(~sel_pkt[b]);
            end else begin
               px_link[b].pkt_l <= '1;
            end
            // Start the next search just past the winner
            if (win_vld[b]) begin
               rr_ptr[b] <= (int'(win_id[b]) == `PCX_N_CORES - 1) ?
                            '0 : win_id[b] + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== pcx_bank_q.sv ====
// PCX bank queues
// One circular buffer per L2 bank, written by the repeater strobe
// and drained by the bank's read pulse. Stall rises early enough
// to absorb every packet already on its way

`timescale 1ns/1ps
`default_nettype none

`include "pcx_consts.svh"

module pcx_bank_q (
   input  logic                        rclk,
   input  logic                        rst_n,
   input  pcx_pkt_pkg::pcx_pkt_t       px2_pkt    [`PCX_N_BANKS],
   input  pcx_link_pkg::pcx_bank_vec_t px2_rdy,
   input  pcx_link_pkg::pcx_bank_vec_t bank_rd,
   output pcx_link_pkg::pcx_bank_vec_t stall_pq,
   output pcx_link_pkg::pcx_bank_vec_t bank_valid,
   output pcx_pkt_pkg::pcx_pkt_t       bank_pkt   [`PCX_N_BANKS]
);

   import pcx_pkt_pkg::*;
   import pcx_link_pkg::*;

   ////////////////////////////////////////
   // Storage and pointers
   ////////////////////////////////////////

   pcx_pkt_t               mem    [`PCX_N_BANKS][`PCX_Q_DEPTH];
   logic [`PCX_Q_PTR_W-1:0] rd_ptr [`PCX_N_BANKS];
   logic [`PCX_Q_PTR_W-1:0] wr_ptr [`PCX_N_BANKS];
   // Occupancy per bank
   logic [`PCX_Q_CNT_W-1:0] count  [`PCX_N_BANKS];

   pcx_bank_vec_t do_wr;
   pcx_bank_vec_t do_rd;

   ////////////////////////////////////////
   // Strobes and status
   ////////////////////////////////////////

   always_comb begin
      for (int b = 0; b < `PCX_N_BANKS; b++) begin
         do_wr[b]      = px2_rdy[b];
         // Read on an empty queue is dropped here
         do_rd[b]      = bank_rd[b] && (count[b] != '0);
         bank_valid[b] = (count[b] != '0);
         // Early stall covers the grant plus two packets in the link
         stall_pq[b]   = (int'(count[b]) >= `PCX_STALL_LVL);
         // Head entry
         bank_pkt[b]   = mem[b][rd_ptr[b]];
      end
   end

   ////////////////////////////////////////
   // Queue memory
   ////////////////////////////////////////

   always_ff @(posedge rclk) begin
      for (int b = 0; b < `PCX_N_BANKS; b++) begin
         if (do_wr[b]) begin
            mem[b][wr_ptr[b]] <= px2_pkt[b];
         end
      end
   end

   ////////////////////////////////////////
   // Pointer and count update
   ////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         for (int b = 0; b < `PCX_N_BANKS; b++) begin
            rd_ptr[b] <= '0;
            wr_ptr[b] <= '0;
            count[b]  <= '0;
         end
      end else begin
         for (int b = 0; b < `PCX_N_BANKS; b++) begin
            // Wrap at the queue depth
            if (do_wr[b]) begin
               wr_ptr[b] <= (int'(wr_ptr[b]) == `PCX_Q_DEPTH - 1) ?
                            '0 : wr_ptr[b] + 1'b1;
            end
            if (do_rd[b]) begin
               rd_ptr[b] <= (int'(rd_ptr[b]) == `PCX_Q_DEPTH - 1) ?
                            '0 : rd_ptr[b] + 1'b1;
            end
            // Push and pop in one cycle leave the count as is
            count[b] <= count[b]
                        + `PCX_Q_CNT_W'(do_wr[b])
                        - `PCX_Q_CNT_W'(do_rd[b]);
         end
      end
   end

endmodule

`default_nettype wire

// ==== pcx_consts.svh ====
// PCX crossbar constants
// Sizes of the core and bank arrays, the bank queues and the packet fields
// shared by both packages and every PCX block

`ifndef PCX_CONSTS_SVH
`define PCX_CONSTS_SVH

// Crossbar dimensions
`define PCX_N_CORES 4
`define PCX_N_BANKS 4

// Per-bank drain queue
`define PCX_Q_DEPTH 8
`define PCX_Q_PTR_W 3
// One extra bit so a full queue is distinct from empty
`define PCX_Q_CNT_W 4
// Two packets can sit in the repeater path when stall rises
`define PCX_STALL_LVL (`PCX_Q_DEPTH - 2)

// Packet field widths
`define PCX_OP_W 3
`define PCX_CORE_W 2
`define PCX_BANK_W 2
`define PCX_ADDR_W 40
`define PCX_DATA_W 64
`define PCX_TAG_W 8

`endif

// ==== pcx_data_px2.sv ====
// PCX link repeater for one bank
// Re-times the bank link by one flop stage, turns the packet back
// to active-high and buffers the bank stall toward the arbiter

`timescale 1ns/1ps
`default_nettype none

`include "pcx_consts.svh"

module pcx_data_px2 (
   input  logic                    rclk,
   input  logic                    rst_n,
   input  pcx_link_pkg::pcx_link_t px_link,
   input  logic                    stall_pq,
   output pcx_pkt_pkg::pcx_pkt_t   px2_pkt,
   output logic                    px2_rdy,
   output logic                    stall_pq_buf
);

   import pcx_pkt_pkg::*;

   // Flopped link still in active-low form
   pcx_pkt_t pkt_l_q;
   logic     rdy_q;

   // Data stage
   always_ff @(posedge rclk) begin
      pkt_l_q <= px_link.pkt_l;
   end

   // Ready stage feeding the queue write strobe
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         rdy_q <= 1'b0;
      end else begin
         rdy_q <= px_link.rdy;
      end
   end

   // Restore active-high data
   assign px2_pkt = pcx_pkt_t'(~pkt_l_q);
   assign px2_rdy = rdy_q;

   // Stall passes straight back
   assign stall_pq_buf = stall_pq;

endmodule

`default_nettype wire

// ==== pcx_link_pkg.sv ====
// PCX link types
// The arbiter to repeater link and the per-bank and per-core
// strobe vectors used between the crossbar blocks

`default_nettype none

`include "pcx_consts.svh"

package pcx_link_pkg;

   ////////////////////////////////////////
   // Bank link
   ////////////////////////////////////////

   // Packet runs active-low up to the repeater
   // Idle link carries all ones
   typedef struct packed {
      pcx_pkt_pkg::pcx_pkt_t pkt_l;
      // One cycle per packet
      logic                  rdy;
   } pcx_link_t;

   ////////////////////////////////////////
   // Strobe vectors
   ////////////////////////////////////////

   // One bit per L2 bank, stall and read
   typedef logic [`PCX_N_BANKS-1:0] pcx_bank_vec_t;

   // One bit per core, request and grant
   typedef logic [`PCX_N_CORES-1:0] pcx_core_vec_t;

endpackage

`default_nettype wire

// ==== pcx_pkt_pkg.sv ====
// PCX packet types
// Opcode encoding and the packed request packet that a core hands
// to the crossbar and that a bank reads out of its queue

`default_nettype none

`include "pcx_consts.svh"

package pcx_pkt_pkg;

   ////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////

   // Request type carried in every packet
   typedef enum logic [`PCX_OP_W-1:0] {
      PCX_OP_LOAD   = 0,
      PCX_OP_STORE  = 1,
      PCX_OP_IFETCH = 2,
      PCX_OP_SWAP   = 3
   } pcx_op_e;

   ////////////////////////////////////////
   // Packet
   ////////////////////////////////////////

   // 119 bits, opcode in the top bits
   typedef struct packed {
      pcx_op_e                 op;
      // Source core, for the return path at the bank
      logic [`PCX_CORE_W-1:0] core_id;
      // Target L2 bank, used for routing
      logic [`PCX_BANK_W-1:0] bank;
      logic [`PCX_ADDR_W-1:0] addr;
      // Store and swap payload, don't care for loads
      logic [`PCX_DATA_W-1:0] data;
      // Sequence number set by the core
      logic [`PCX_TAG_W-1:0]  tag;
   } pcx_pkt_t;

endpackage

`default_nettype wire

// ==== pcx_top.sv ====
// PCX crossbar top
// Four core ports arbitrated per L2 bank, one link repeater per bank
// and the bank drain queues. Grant to queue write takes two cycles

`timescale 1ns/1ps
`default_nettype none

`include "pcx_consts.svh"

module pcx_top (
   input  logic                        rclk,
   input  logic                        rst_n,
   input  pcx_link_pkg::pcx_core_vec_t core_req,
   input  pcx_pkt_pkg::pcx_pkt_t       core_pkt   [`PCX_N_CORES],
   output pcx_link_pkg::pcx_core_vec_t core_gnt,
   input  pcx_link_pkg::pcx_bank_vec_t bank_rd,
   output pcx_link_pkg::pcx_bank_vec_t bank_valid,
   output pcx_pkt_pkg::pcx_pkt_t       bank_pkt   [`PCX_N_BANKS]
);

   import pcx_pkt_pkg::*;
   import pcx_link_pkg::*;

   ////////////////////////////////////////
   // Internal links
   ////////////////////////////////////////

   // Arbiter to repeater, active-low packet
   pcx_link_t     px_link [`PCX_N_BANKS];
   // Repeater to queue, active-high packet
   pcx_pkt_t      px2_pkt [`PCX_N_BANKS];
   pcx_bank_vec_t px2_rdy;
   // Stall from the queues and its buffered copy
   pcx_bank_vec_t stall_pq;
   pcx_bank_vec_t stall_pq_buf;

   ////////////////////////////////////////
   // Arbiter
   ////////////////////////////////////////

   pcx_arb u_arb (
      .rclk         (rclk),
      .rst_n        (rst_n),
      .core_req     (core_req),
      .core_pkt     (core_pkt),
      .stall_pq_buf (stall_pq_buf),
      .core_gnt     (core_gnt),
      .px_link      (px_link)
   );

   // One repeater per bank
   for (genvar b = 0; b < `PCX_N_BANKS; b++) begin : gen_px2
      pcx_data_px2 u_data_px2 (
         .rclk         (rclk),
         .rst_n        (rst_n),
         .px_link      (px_link[b]),
         .stall_pq     (stall_pq[b]),
         .px2_pkt      (px2_pkt[b]),
         .px2_rdy      (px2_rdy[b]),
         .stall_pq_buf (stall_pq_buf[b])
      );
   end

   ////////////////////////////////////////
   // Bank queues
   ////////////////////////////////////////

   pcx_bank_q u_bank_q (
      .rclk       (rclk),
      .rst_n      (rst_n),
      .px2_pkt    (px2_pkt),
      .px2_rdy    (px2_rdy),
      .bank_rd    (bank_rd),
      .stall_pq   (stall_pq),
      .bank_valid (bank_valid),
      .bank_pkt   (bank_pkt)
   );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the PCX crossbar testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module tb_pcx -o sim_pcx
./obj_dir/sim_pcx | tee sim.log

if grep -q "All tests passed!" sim.log; then
   echo "Simulation PASS"
   exit 0
else
   echo "Simulation FAIL"
   exit 1
fi

// ==== sim.f ====
+incdir+.
pcx_pkt_pkg.sv
pcx_link_pkg.sv
pcx_arb.sv
pcx_data_px2.sv
pcx_bank_q.sv
pcx_top.sv
tb_pcx.sv

// ==== tb_pcx.sv ====
// PCX crossbar testbench
// Drives the four core ports from a table of packet bursts, drains the
// bank ports and checks every packet against a per core and bank scoreboard

`timescale 1ns/1ps
`default_nettype none

`include "pcx_consts.svh"

module tb_pcx;

   import pcx_pkt_pkg::*;
   import pcx_link_pkg::*;

   // Bank read modes
   localparam int rd_hold = 0;
   localparam int rd_on   = 1;
   localparam int rd_rand = 2;
   localparam int n_rows  = 18;
   localparam int drain_limit = 400;

   // One burst of packets from one core to one bank
   typedef struct packed {
      int                     test;
      int                     core;
      pcx_op_e                op;
      int                     bank;
      logic [`PCX_ADDR_W-1:0] addr;
      logic [`PCX_DATA_W-1:0] data;
      int                     reps;
      int                     mode;
   } row_t;

   logic          rclk;
   logic          rst_n;
   pcx_core_vec_t core_req;
   pcx_pkt_t      core_pkt   [`PCX_N_CORES];
   pcx_core_vec_t core_gnt;
   pcx_bank_vec_t bank_rd;
   pcx_bank_vec_t bank_valid;
   pcx_pkt_t      bank_pkt   [`PCX_N_BANKS];

   row_t                  tbl     [n_rows];
   // Packets waiting for a grant
   pcx_pkt_t              pend_q  [`PCX_N_CORES][$];
   // Granted packets not yet read per core and bank
   pcx_pkt_t              exp_q   [`PCX_N_CORES][`PCX_N_BANKS][$];
   logic [`PCX_TAG_W-1:0] tag_cnt [`PCX_N_CORES];
   int                    gnt_cnt [`PCX_N_BANKS];
   int                    rd_mode;
   // Bank under round-robin watch or -1 for none
   int                    fair_bank;
   pcx_core_vec_t         seen;
   int                    err_cnt;
   int                    test_err;
   int                    n_tests;
   int                    n_checks;

   pcx_top DUT (
      .rclk       (rclk),
      .rst_n      (rst_n),
      .core_req   (core_req),
      .core_pkt   (core_pkt),
      .core_gnt   (core_gnt),
      .bank_rd    (bank_rd),
      .bank_valid (bank_valid),
      .bank_pkt   (bank_pkt)
   );

   // 10 ns clock
   always #5 rclk = ~rclk;

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   task automatic check_val(input logic [127:0] got, input logic [127:0] exp,
                            input string msg);
      n_checks++;
      if (got !== exp) begin
         $display("MISMATCH @%0t: %s, got %h expected %h", $time, msg, got, exp);
         err_cnt++;
         test_err++;
      end
   endtask

   task automatic note_error(input string msg);
      $display("ERROR @%0t: %s", $time, msg);
      err_cnt++;
      test_err++;
   endtask

   function automatic bit busy();
      bit any;
      any = 1'b0;
      for (int c = 0; c < `PCX_N_CORES; c++) begin
         if (pend_q[c].size() != 0) begin
            any = 1'b1;
         end
         for (int b = 0; b < `PCX_N_BANKS; b++) begin
            if (exp_q[c][b].size() != 0) begin
               any = 1'b1;
            end
         end
      end
      return any;
   endfunction

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   // Present each core queue head and the read pulses of the mode
   task automatic drive_inputs();
      for (int c = 0; c < `PCX_N_CORES; c++) begin
         core_req[c] = (pend_q[c].size() != 0);
         core_pkt[c] = '0;
         if (pend_q[c].size() != 0) begin
            core_pkt[c] = pend_q[c][0];
         end
      end
      for (int b = 0; b < `PCX_N_BANKS; b++) begin
         case (rd_mode)
            rd_on:   bank_rd[b] = 1'b1;
            rd_rand: bank_rd[b] = ($urandom % 3) != 0;
            default: bank_rd[b] = 1'b0;
         endcase
      end
   endtask

   // Sample at the falling edge and drive 1 ns after the rising edge
   task automatic step();
      pcx_pkt_t      p;
      pcx_pkt_t      e;
      pcx_core_vec_t others;
      @(negedge rclk);
      for (int c = 0; c < `PCX_N_CORES; c++) begin
         if (core_gnt[c] && pend_q[c].size() == 0) begin
            note_error($sformatf("grant to core %0d without a request", c));
         end else if (core_gnt[c]) begin
            p = pend_q[c].pop_front();
            exp_q[c][p.bank].push_back(p);
            gnt_cnt[p.bank]++;
            if (fair_bank == int'(p.bank)) begin
               // All other waiting cores win before c wins again
               if (seen[c]) begin
                  others = core_req & ~(pcx_core_vec_t'(1) << c);
                  check_val(128'(others & ~seen), 128'(0), "core granted twice in one round");
                  seen = '0;
               end
               seen[c] = 1'b1;
            end
         end
      end
      // Pop takes effect at the coming edge
      for (int b = 0; b < `PCX_N_BANKS; b++) begin
         if (bank_rd[b] && bank_valid[b]) begin
            p = bank_pkt[b];
            check_val(128'(p.bank), 128'(b), "packet at wrong bank port");
            if (exp_q[p.core_id][b].size() == 0) begin
               note_error($sformatf("bank %0d delivered a packet that was never granted", b));
            end else begin
               e = exp_q[p.core_id][b].pop_front();
               check_val(128'(p), 128'(e), "packet contents");
            end
         end
      end
      @(posedge rclk);
      #1;
      drive_inputs();
   endtask

   // Expand the rows of one test into per core queues
   task automatic load_test(input int t);
      pcx_pkt_t p;
      for (int r = 0; r < n_rows; r++) begin
         if (tbl[r].test == t) begin
            rd_mode = tbl[r].mode;
            for (int k = 0; k < tbl[r].reps; k++) begin
               p.op      = tbl[r].op;
               p.core_id = `PCX_CORE_W'(tbl[r].core);
               p.bank    = `PCX_BANK_W'(tbl[r].bank);
               p.addr    = tbl[r].addr + `PCX_ADDR_W'(k * 8);
               p.data    = tbl[r].data ^ `PCX_DATA_W'(k);
               p.tag     = tag_cnt[tbl[r].core];
               tag_cnt[tbl[r].core]++;
               pend_q[tbl[r].core].push_back(p);
            end
         end
      end
      for (int b = 0; b < `PCX_N_BANKS; b++) begin
         gnt_cnt[b] = 0;
      end
      test_err = 0;
      seen     = '0;
      drive_inputs();
   endtask

   task automatic drain(input int t);
      int cyc;
      cyc = 0;
      while (busy()) begin
         if (cyc >= drain_limit) begin
            note_error($sformatf("timeout: test %0d still had packets after %0d cycles",
                                 t, cyc));
            return;
         end
         step();
         cyc++;
      end
   endtask

   task automatic finish_test(input int t, input string name);
      n_tests++;
      $display("Test %0d %s: %s, %0d errors", t, name,
               (test_err == 0) ? "ok" : "FAILED", test_err);
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      void'($urandom(94));
      rclk      = 1'b0;
      rst_n     = 1'b0;
      core_req  = '0;
      bank_rd   = '0;
      rd_mode   = rd_hold;
      fair_bank = -1;
      seen      = '0;
      err_cnt   = 0;
      test_err  = 0;
      n_tests   = 0;
      n_checks  = 0;
      for (int c = 0; c < `PCX_N_CORES; c++) begin
         core_pkt[c] = '0;
         tag_cnt[c]  = '0;
      end
      // test, core, op, bank, addr, data, reps, read mode
      tbl[0]  = '{2, 1, PCX_OP_LOAD,   0, 40'h00_0000_1000, 64'h0123_4567_89ab_cdef, 1, rd_on};
      tbl[1]  = '{2, 1, PCX_OP_STORE,  1, 40'hff_8000_0040, 64'hfedc_ba98_7654_3210, 1, rd_on};
      tbl[2]  = '{2, 1, PCX_OP_IFETCH, 2, 40'h5a_a5a5_0080, 64'h0000_0000_0000_0000, 1, rd_on};
      tbl[3]  = '{2, 1, PCX_OP_SWAP,   3, 40'h12_3456_78c0, 64'hffff_ffff_ffff_ffff, 1, rd_on};
      // Same bank from every core
      tbl[4]  = '{3, 0, PCX_OP_STORE,  1, 40'h01_0000_0000, 64'h1111_0000_0000_0001, 3, rd_on};
      tbl[5]  = '{3, 1, PCX_OP_STORE,  1, 40'h02_0000_0000, 64'h2222_0000_0000_0002, 3, rd_on};
      tbl[6]  = '{3, 2, PCX_OP_LOAD,   1, 40'h03_0000_0000, 64'h3333_0000_0000_0003, 3, rd_on};
      tbl[7]  = '{3, 3, PCX_OP_SWAP,   1, 40'h04_0000_0000, 64'h4444_0000_0000_0004, 3, rd_on};
      // Flood with reads held off
      tbl[8]  = '{4, 0, PCX_OP_LOAD,   2, 40'h10_0000_0100, 64'ha0a0_0000_0000_0000, 3, rd_hold};
      tbl[9]  = '{4, 1, PCX_OP_STORE,  2, 40'h20_0000_0200, 64'hb1b1_0000_0000_0000, 3, rd_hold};
      tbl[10] = '{4, 2, PCX_OP_IFETCH, 2, 40'h30_0000_0300, 64'hc2c2_0000_0000_0000, 3, rd_hold};
      tbl[11] = '{4, 3, PCX_OP_SWAP,   2, 40'h40_0000_0400, 64'hd3d3_0000_0000_0000, 3, rd_hold};
      // Mixed traffic with random read gaps
      tbl[12] = '{5, 0, PCX_OP_STORE,  3, 40'h0a_0000_1000, 64'h0a0a_0a0a_0000_0000, 4, rd_rand};
      tbl[13] = '{5, 1, PCX_OP_LOAD,   0, 40'h0b_0000_2000, 64'h0b0b_0b0b_0000_0000, 3, rd_rand};
      tbl[14] = '{5, 2, PCX_OP_SWAP,   3, 40'h0c_0000_3000, 64'h0c0c_0c0c_0000_0000, 3, rd_rand};
      tbl[15] = '{5, 3, PCX_OP_IFETCH, 1, 40'h0d_0000_4000, 64'h0d0d_0d0d_0000_0000, 4, rd_rand};
      tbl[16] = '{5, 0, PCX_OP_LOAD,   2, 40'h0e_0000_5000, 64'h0e0e_0e0e_0000_0000, 2, rd_rand};
      tbl[17] = '{5, 2, PCX_OP_STORE,  0, 40'h0f_0000_6000, 64'h0f0f_0f0f_0000_0000, 3, rd_rand};

      repeat (5) @(posedge rclk);
      #1;
      rst_n = 1'b1;

      // Nothing moves without requests
      for (int i = 0; i < 10; i++) begin
         @(negedge rclk);
         check_val(128'(core_gnt), 128'(0), "grant while idle");
         check_val(128'(bank_valid), 128'(0), "bank valid while idle");
      end
      @(posedge rclk);
      #1;
      finish_test(1, "idle after reset");

      load_test(2);
      drain(2);
      finish_test(2, "one packet per bank");

      fair_bank = 1;
      load_test(3);
      drain(3);
      finish_test(3, "round-robin on one bank");
      fair_bank = -1;

      // Stall at depth minus two leaves room for both packets in flight
      load_test(4);
      repeat (20) step();
      check_val(128'(gnt_cnt[2]), 128'(`PCX_Q_DEPTH), "grants before stall held");
      rd_mode = rd_on;
      drain(4);
      finish_test(4, "stall and resume");

      load_test(5);
      drain(5);
      // Reads on empty queues must leave them empty
      rd_mode = rd_on;
      repeat (4) step();
      @(negedge rclk);
      check_val(128'(bank_valid), 128'(0), "valid after reads on empty queues");
      check_val(128'(busy()), 128'(0), "scoreboard not empty");
      @(posedge rclk);
      #1;
      finish_test(5, "mixed traffic");

      $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire
